//--- logic/dma_pkg.sv
/*
 * DMA backend shared definitions
 * Widths, vector types, request and burst structs, FSM encodings
 */
package dma_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned ADDR_WIDTH = 16;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned LEN_WIDTH  = 12;

    // Word address, data word, length in words
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [LEN_WIDTH-1:0]  len_t;

    // ------------------------------
    // Transfer and burst descriptors
    // ------------------------------
    // One 1D transfer as requested from outside
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        len_t  length;
    } xfer_req_t;

    // One page-legal burst, last flags the final burst of a transfer
    typedef struct packed {
        addr_t addr;
        len_t  length;
        logic  last;
    } burst_t;

    // ------------------------------
    // FSM states
    // ------------------------------
    typedef enum logic {LEG_IDLE, LEG_SPLIT} leg_state_e;
    typedef enum logic {RD_IDLE, RD_ISSUE} rd_state_e;
    typedef enum logic {WR_IDLE, WR_WRITE} wr_state_e;

endpackage

//--- logic/dma_legalizer.sv
/*
 * DMA transfer legalizer
 * Holds one transfer and cuts it into bursts that cross neither a
 * source nor a destination page boundary and stay within the maximum
 * burst length. Read and write commands are issued as a coupled pair.
 */
`timescale 1ns/1ps

module dma_legalizer #(
    parameter int unsigned PageWords     = 64,
    parameter int unsigned MaxBurstWords = 16
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Transfer request
    input  dma_pkg::xfer_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    // Read command
    output dma_pkg::burst_t    rd_cmd_o,
    output logic               rd_cmd_valid_o,
    input  logic               rd_cmd_ready_i,
    // Write command
    output dma_pkg::burst_t    wr_cmd_o,
    output logic               wr_cmd_valid_o,
    input  logic               wr_cmd_ready_i
);

    // Page offset bits of a word address
    localparam int unsigned PageBits = $clog2(PageWords);

    dma_pkg::leg_state_e state_q;
    dma_pkg::leg_state_e state_d;

    // Remaining part of the active transfer
    dma_pkg::addr_t src_q;
    dma_pkg::addr_t dst_q;
    dma_pkg::len_t  len_q;

    // Distances to the next page boundaries
    dma_pkg::len_t src_to_pb;
    dma_pkg::len_t dst_to_pb;
    dma_pkg::len_t page_len;
    dma_pkg::len_t cap_len;
    dma_pkg::len_t burst_len;
    logic          burst_last;

    logic req_hs;
    logic cmd_hs;

    // ------------------------------
    // Burst length
    // ------------------------------
    // Words left in the current source and destination page
    assign src_to_pb = dma_pkg::len_t'(PageWords)
                     - dma_pkg::len_t'(src_q[PageBits-1:0]);
    assign dst_to_pb = dma_pkg::len_t'(PageWords)
                     - dma_pkg::len_t'(dst_q[PageBits-1:0]);

    // Nearer boundary wins, same cut for read and write
    assign page_len = (src_to_pb < dst_to_pb) ? src_to_pb : dst_to_pb;

    // Clip to burst maximum
    assign cap_len = (page_len < dma_pkg::len_t'(MaxBurstWords)) ?
                     page_len : dma_pkg::len_t'(MaxBurstWords);

    // Remainder fits, so this is the final burst
    assign burst_last = (len_q <= cap_len);
    assign burst_len  = burst_last ? len_q : cap_len;

    // ------------------------------
    // Coupled flow control
    // ------------------------------
    assign req_ready_o = (state_q == dma_pkg::LEG_IDLE);
    assign req_hs      = req_valid_i & req_ready_o;

    // Each valid waits for the other engine, both commands go together
    assign rd_cmd_valid_o = (state_q == dma_pkg::LEG_SPLIT) & wr_cmd_ready_i;
    assign wr_cmd_valid_o = (state_q == dma_pkg::LEG_SPLIT) & rd_cmd_ready_i;
    assign cmd_hs         = (state_q == dma_pkg::LEG_SPLIT)
                          & rd_cmd_ready_i & wr_cmd_ready_i;

    // Same length on both sides
    assign rd_cmd_o = '{addr: src_q, length: burst_len, last: burst_last};
    assign wr_cmd_o = '{addr: dst_q, length: burst_len, last: burst_last};

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::LEG_IDLE: begin
                // First burst offered the cycle after acceptance
                if (req_hs) begin
                    state_d = dma_pkg::LEG_SPLIT;
                end
            end
            dma_pkg::LEG_SPLIT: begin
                if (cmd_hs && burst_last) begin
                    state_d = dma_pkg::LEG_IDLE;
                end
            end
            default: state_d = dma_pkg::LEG_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dma_pkg::LEG_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Transfer registers, loaded on accept and advanced per burst
    always_ff @(posedge clk_i) begin
        if (req_hs) begin
            src_q <= req_i.src_addr;
            dst_q <= req_i.dst_addr;
            len_q <= req_i.length;
        end else if (cmd_hs) begin
            src_q <= src_q + dma_pkg::addr_t'(burst_len);
            dst_q <= dst_q + dma_pkg::addr_t'(burst_len);
            len_q <= len_q - burst_len;
        end
    end

endmodule

//--- logic/dma_read_engine.sv
/*
 * DMA read engine
 * Walks one read burst word by word on the source port. Reads are
 * only issued while the data FIFO has room for every word in flight.
 */
`timescale 1ns/1ps

module dma_read_engine #(
    parameter int unsigned FifoDepth = 8
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    // Burst command
    input  dma_pkg::burst_t                    cmd_i,
    input  logic                               cmd_valid_i,
    output logic                               cmd_ready_o,
    // Source read port
    output dma_pkg::addr_t                     rd_addr_o,
    output logic                               rd_valid_o,
    input  logic                               rd_ready_i,
    input  logic                               rd_rsp_valid_i,
    input  dma_pkg::data_t                     rd_rsp_data_i,
    // Buffer side
    input  logic [$clog2(FifoDepth):0]         fifo_level_i,
    output logic                               push_o,
    output dma_pkg::data_t                     push_data_o
);

    localparam int unsigned LevelWidth = $clog2(FifoDepth) + 1;

    dma_pkg::rd_state_e state_q;
    dma_pkg::rd_state_e state_d;

    // Burst walk
    dma_pkg::addr_t addr_q;
    dma_pkg::len_t  cnt_q;

    // Reads issued but not yet answered
    logic [LevelWidth-1:0] outstanding_q;
    logic [LevelWidth:0]   credit_used;
    logic                  credit_ok;

    logic cmd_hs;
    logic rd_hs;

    assign cmd_ready_o = (state_q == dma_pkg::RD_IDLE);
    assign cmd_hs      = cmd_valid_i & cmd_ready_o;

    // ------------------------------
    // Credit check
    // ------------------------------
    // Words in flight plus buffered words must leave a free slot
    assign credit_used = {1'b0, outstanding_q} + {1'b0, fifo_level_i};
    assign credit_ok   = (credit_used < (LevelWidth + 1)'(FifoDepth));

    assign rd_valid_o = (state_q == dma_pkg::RD_ISSUE) & credit_ok;
    assign rd_addr_o  = addr_q;
    assign rd_hs      = rd_valid_o & rd_ready_i;

    // Responses go straight into the buffer
    assign push_o      = rd_rsp_valid_i;
    assign push_data_o = rd_rsp_data_i;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::RD_IDLE:  if (cmd_hs) state_d = dma_pkg::RD_ISSUE;
            dma_pkg::RD_ISSUE: if (rd_hs && cnt_q == dma_pkg::len_t'(1)) state_d = dma_pkg::RD_IDLE;
            default:           state_d = dma_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= dma_pkg::RD_IDLE;
            cnt_q         <= '0;
            outstanding_q <= '0;
        end else begin
            state_q <= state_d;
            if (cmd_hs) begin
                cnt_q <= cmd_i.length;
            end else if (rd_hs) begin
                cnt_q <= cnt_q - dma_pkg::len_t'(1);
            end
            // Issue and return may coincide
            if (rd_hs && !rd_rsp_valid_i) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (!rd_hs && rd_rsp_valid_i) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
        end
    end

    // Read address
    always_ff @(posedge clk_i) begin
        if (cmd_hs) begin
            addr_q <= cmd_i.addr;
        end else if (rd_hs) begin
            addr_q <= addr_q + dma_pkg::addr_t'(1);
        end
    end

endmodule

//--- logic/dma_data_fifo.sv
/*
 * DMA data FIFO
 * Circular word buffer between read and write engine. Push and pop
 * may happen in the same cycle, the fill level feeds read credit.
 */
`timescale 1ns/1ps

module dma_data_fifo #(
    parameter int unsigned FifoDepth = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Write side, space guaranteed by read credit
    input  logic                       push_i,
    input  dma_pkg::data_t             push_data_i,
    // Read side
    output dma_pkg::data_t             pop_data_o,
    output logic                       pop_valid_o,
    input  logic                       pop_ready_i,
    // Fill level
    output logic [$clog2(FifoDepth):0] level_o
);

    localparam int unsigned PtrWidth   = $clog2(FifoDepth);
    localparam int unsigned LevelWidth = PtrWidth + 1;

    // Storage
    dma_pkg::data_t mem_q [FifoDepth];

    logic [PtrWidth-1:0]   wr_ptr_q;
    logic [PtrWidth-1:0]   rd_ptr_q;
    logic [LevelWidth-1:0] count_q;

    logic pop_hs;

    assign pop_valid_o = (count_q != '0);
    assign pop_data_o  = mem_q[rd_ptr_q];
    assign pop_hs      = pop_valid_o & pop_ready_i;
    assign level_o     = count_q;

    // ------------------------------
    // Pointers and count
    // ------------------------------
    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_hs) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_i && !pop_hs) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && pop_hs) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Word store, visible to pop from the next cycle
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

//--- logic/dma_write_engine.sv
/*
 * DMA write engine
 * Drains one write burst from the data FIFO onto the destination
 * port, marks the final word of the burst and pulses done once the
 * last burst of a transfer has been written.
 */
`timescale 1ns/1ps

module dma_write_engine (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Burst command
    input  dma_pkg::burst_t cmd_i,
    input  logic            cmd_valid_i,
    output logic            cmd_ready_o,
    // FIFO side
    input  dma_pkg::data_t  pop_data_i,
    input  logic            pop_valid_i,
    output logic            pop_ready_o,
    // Destination write port
    output dma_pkg::addr_t  wr_addr_o,
    output dma_pkg::data_t  wr_data_o,
    output logic            wr_last_o,
    output logic            wr_valid_o,
    input  logic            wr_ready_i,
    // Transfer complete
    output logic            done_o
);

    dma_pkg::wr_state_e state_q;
    dma_pkg::wr_state_e state_d;

    // Burst walk
    dma_pkg::addr_t addr_q;
    dma_pkg::len_t  cnt_q;
    logic           xfer_last_q;

    logic done_q;
    logic cmd_hs;
    logic wr_hs;
    logic burst_end;

    assign cmd_ready_o = (state_q == dma_pkg::WR_IDLE);
    assign cmd_hs      = cmd_valid_i & cmd_ready_o;

    // ------------------------------
    // Write channel
    // ------------------------------
    // Offer a word as soon as the buffer has one
    assign wr_valid_o = (state_q == dma_pkg::WR_WRITE) & pop_valid_i;
    assign wr_addr_o  = addr_q;
    assign wr_data_o  = pop_data_i;
    assign burst_end  = (cnt_q == dma_pkg::len_t'(1));
    assign wr_last_o  = burst_end;

    // Pop only when the port takes the word
    assign pop_ready_o = (state_q == dma_pkg::WR_WRITE) & wr_ready_i;
    assign wr_hs       = wr_valid_o & wr_ready_i;

    assign done_o = done_q;

    // ------------------------------
    // FSM
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::WR_IDLE:  if (cmd_hs) state_d = dma_pkg::WR_WRITE;
            dma_pkg::WR_WRITE: if (wr_hs && burst_end) state_d = dma_pkg::WR_IDLE;
            default:           state_d = dma_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= dma_pkg::WR_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (cmd_hs) begin
                cnt_q <= cmd_i.length;
            end else if (wr_hs) begin
                cnt_q <= cnt_q - dma_pkg::len_t'(1);
            end
            // One cycle pulse after the final word of the transfer
            done_q <= wr_hs & burst_end & xfer_last_q;
        end
    end

    // Destination address and transfer end flag
    always_ff @(posedge clk_i) begin
        if (cmd_hs) begin
            addr_q      <= cmd_i.addr;
            xfer_last_q <= cmd_i.last;
        end else if (wr_hs) begin
            addr_q <= addr_q + dma_pkg::addr_t'(1);
        end
    end

endmodule

//--- logic/dma_backend.sv
/*
 * DMA backend top level
 * Legalizer feeding coupled read and write engines that are joined
 * by a word FIFO. Carries the page, burst and buffer parameters.
 */
`timescale 1ns/1ps

module dma_backend #(
    parameter int unsigned PageWords     = 64,
    parameter int unsigned MaxBurstWords = 16,
    parameter int unsigned FifoDepth     = 8
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Transfer request
    input  dma_pkg::xfer_req_t req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    // Source read port
    output dma_pkg::addr_t     rd_addr_o,
    output logic               rd_valid_o,
    input  logic               rd_ready_i,
    input  logic               rd_rsp_valid_i,
    input  dma_pkg::data_t     rd_rsp_data_i,
    // Destination write port
    output dma_pkg::addr_t     wr_addr_o,
    output dma_pkg::data_t     wr_data_o,
    output logic               wr_last_o,
    output logic               wr_valid_o,
    input  logic               wr_ready_i,
    // Transfer complete
    output logic               done_o
);

    // ------------------------------
    // Internal wiring
    // ------------------------------
    dma_pkg::burst_t rd_cmd;
    logic            rd_cmd_valid;
    logic            rd_cmd_ready;
    dma_pkg::burst_t wr_cmd;
    logic            wr_cmd_valid;
    logic            wr_cmd_ready;

    logic                       push;
    dma_pkg::data_t             push_data;
    dma_pkg::data_t             pop_data;
    logic                       pop_valid;
    logic                       pop_ready;
    logic [$clog2(FifoDepth):0] fifo_level;

    // Burst splitter
    dma_legalizer #(
        .PageWords     (PageWords),
        .MaxBurstWords (MaxBurstWords)
    ) dma_legalizer_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .rd_cmd_o       (rd_cmd),
        .rd_cmd_valid_o (rd_cmd_valid),
        .rd_cmd_ready_i (rd_cmd_ready),
        .wr_cmd_o       (wr_cmd),
        .wr_cmd_valid_o (wr_cmd_valid),
        .wr_cmd_ready_i (wr_cmd_ready)
    );

    // Source side
    dma_read_engine #(
        .FifoDepth (FifoDepth)
    ) dma_read_engine_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cmd_i          (rd_cmd),
        .cmd_valid_i    (rd_cmd_valid),
        .cmd_ready_o    (rd_cmd_ready),
        .rd_addr_o      (rd_addr_o),
        .rd_valid_o     (rd_valid_o),
        .rd_ready_i     (rd_ready_i),
        .rd_rsp_valid_i (rd_rsp_valid_i),
        .rd_rsp_data_i  (rd_rsp_data_i),
        .fifo_level_i   (fifo_level),
        .push_o         (push),
        .push_data_o    (push_data)
    );

    // Word buffer
    dma_data_fifo #(
        .FifoDepth (FifoDepth)
    ) dma_data_fifo_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_data_o  (pop_data),
        .pop_valid_o (pop_valid),
        .pop_ready_i (pop_ready),
        .level_o     (fifo_level)
    );

    // Destination side
    dma_write_engine dma_write_engine_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_i       (wr_cmd),
        .cmd_valid_i (wr_cmd_valid),
        .cmd_ready_o (wr_cmd_ready),
        .pop_data_i  (pop_data),
        .pop_valid_i (pop_valid),
        .pop_ready_o (pop_ready),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .wr_last_o   (wr_last_o),
        .wr_valid_o  (wr_valid_o),
        .wr_ready_i  (wr_ready_i),
        .done_o      (done_o)
    );

endmodule

//--- testbench/tb_mem_model.sv
/*
 * Memory model for the DMA backend testbench
 * Source side returns one pattern word per address, in order, one to
 * three cycles after the address is taken, with random address stalls.
 * Destination side is a write sink with random back-pressure.
 */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter dma_pkg::data_t Pattern = 32'h0
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    // Source read port
    input  dma_pkg::addr_t rd_addr_i,
    input  logic           rd_valid_i,
    output logic           rd_ready_o,
    output logic           rd_rsp_valid_o,
    output dma_pkg::data_t rd_rsp_data_o,
    // Destination write port
    output logic           wr_ready_o,
    // Stall chance in percent
    input  int unsigned    rd_stall_pct_i,
    input  int unsigned    wr_stall_pct_i
);

    // Pending responses and the cycle each becomes visible
    dma_pkg::data_t rsp_data_q [$];
    longint         rsp_due_q [$];
    longint         cycle_cnt;
    longint         last_due;

    initial begin
        rd_ready_o     = 1'b0;
        rd_rsp_valid_o = 1'b0;
        rd_rsp_data_o  = '0;
        wr_ready_o     = 1'b0;
        cycle_cnt      = 0;
        last_due       = 0;
    end

    always @(posedge clk_i) begin : mem_step
        longint      due;
        logic        in_reset;
        int unsigned rd_pct;
        int unsigned wr_pct;
        // Everything sampled at the edge
        in_reset = !rst_n_i;
        rd_pct   = rd_stall_pct_i;
        wr_pct   = wr_stall_pct_i;
        if (in_reset) begin
            rsp_data_q.delete();
            rsp_due_q.delete();
            cycle_cnt = 0;
            last_due  = 0;
        end else begin
            cycle_cnt = cycle_cnt + 1;
            // Word on the response bus was consumed at this edge
            if (rd_rsp_valid_o) begin
                rsp_data_q.delete(0);
                rsp_due_q.delete(0);
            end
            // Address taken, data follows one to three cycles later
            if (rd_valid_i && rd_ready_o) begin
                due = cycle_cnt + longint'($urandom_range(2));
                // Keep responses in order
                if (due < last_due) begin
                    due = last_due;
                end
                last_due = due;
                rsp_data_q.push_back({rd_addr_i, rd_addr_i} ^ Pattern);
                rsp_due_q.push_back(due);
            end
        end
        #1;
        if (in_reset) begin
            rd_ready_o     = 1'b0;
            rd_rsp_valid_o = 1'b0;
            wr_ready_o     = 1'b0;
        end else begin
            rd_ready_o = ($urandom_range(99) >= rd_pct);
            wr_ready_o = ($urandom_range(99) >= wr_pct);
            if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle_cnt) begin
                rd_rsp_valid_o = 1'b1;
                rd_rsp_data_o  = rsp_data_q[0];
            end else begin
                rd_rsp_valid_o = 1'b0;
            end
        end
    end

endmodule

//--- testbench/tb_dma_backend.sv
/*
 * Testbench for the DMA backend
 * Directed transfers against a memory model, every destination write
 * checked against a queue predicted from the page and burst rules
 */
`timescale 1ns/1ps

module tb_dma_backend;

    localparam int unsigned    PageWords     = 64;
    localparam int unsigned    MaxBurstWords = 16;
    localparam int unsigned    Seed          = 32'hfd41deaa;
    localparam dma_pkg::data_t Pattern       = 32'h9e37_c5a1;

    // One expected destination write
    typedef struct packed {
        dma_pkg::addr_t addr;
        dma_pkg::data_t data;
        logic           last;
    } exp_write_t;

    logic               clk;
    logic               rst_n;
    dma_pkg::xfer_req_t req;
    logic               req_valid;
    logic               req_ready;
    dma_pkg::addr_t     rd_addr;
    logic               rd_valid;
    logic               rd_ready;
    logic               rd_rsp_valid;
    dma_pkg::data_t     rd_rsp_data;
    dma_pkg::addr_t     wr_addr;
    dma_pkg::data_t     wr_data;
    logic               wr_last;
    logic               wr_valid;
    logic               wr_ready;
    logic               done;
    int unsigned        rd_stall_pct;
    int unsigned        wr_stall_pct;

    // Scoreboard state
    exp_write_t  exp_q [$];
    int unsigned exp_done;
    int unsigned exp_bursts;
    int unsigned done_count;
    int unsigned last_count;
    int unsigned requested_words;
    int unsigned cycle_cnt;
    int unsigned checks;
    int unsigned errors;

    dma_backend dma_backend_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .req_i          (req),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .rd_addr_o      (rd_addr),
        .rd_valid_o     (rd_valid),
        .rd_ready_i     (rd_ready),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_data_i  (rd_rsp_data),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .wr_last_o      (wr_last),
        .wr_valid_o     (wr_valid),
        .wr_ready_i     (wr_ready),
        .done_o         (done)
    );

    tb_mem_model #(
        .Pattern (Pattern)
    ) tb_mem_model_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .rd_addr_i      (rd_addr),
        .rd_valid_i     (rd_valid),
        .rd_ready_o     (rd_ready),
        .rd_rsp_valid_o (rd_rsp_valid),
        .rd_rsp_data_o  (rd_rsp_data),
        .wr_ready_o     (wr_ready),
        .rd_stall_pct_i (rd_stall_pct),
        .wr_stall_pct_i (wr_stall_pct)
    );

    always #5 clk = ~clk;

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic compare_addr(input dma_pkg::addr_t got, input dma_pkg::addr_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_data(input dma_pkg::data_t got, input dma_pkg::data_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_last(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int unsigned got, input int unsigned exp,
                                 input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // Monitor and watchdog
    // ------------------------------
    always @(posedge clk) begin : write_monitor
        exp_write_t exp_w;
        if (rst_n && wr_valid && wr_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected write to address %h while no word was expected",
                         wr_addr);
            end else begin
                exp_w = exp_q.pop_front();
                compare_addr(wr_addr, exp_w.addr, "write address");
                compare_data(wr_data, exp_w.data, "write data");
                compare_last(wr_last, exp_w.last, "write last");
            end
            if (wr_last) begin
                last_count++;
            end
        end
        if (rst_n && done) begin
            done_count++;
        end
    end

    // Budget grows with every requested word
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 500 + 20 * requested_words) begin
            $display("Timeout after %0d cycles, a transfer did not complete", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic dma_pkg::data_t src_pattern(input dma_pkg::addr_t addr);
        return {addr, addr} ^ Pattern;
    endfunction

    // Nearer page boundary, burst maximum, remainder
    task automatic predict_transfer(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                                    input int unsigned len);
        int unsigned rem;
        int unsigned s_room;
        int unsigned d_room;
        int unsigned blen;
        exp_write_t  w;
        rem = len;
        while (rem > 0) begin
            s_room = PageWords - (src % PageWords);
            d_room = PageWords - (dst % PageWords);
            blen   = (s_room < d_room) ? s_room : d_room;
            if (blen > MaxBurstWords) begin
                blen = MaxBurstWords;
            end
            if (blen > rem) begin
                blen = rem;
            end
            for (int unsigned i = 0; i < blen; i++) begin
                w.addr = dma_pkg::addr_t'(dst + i);
                w.data = src_pattern(dma_pkg::addr_t'(src + i));
                w.last = (i == blen - 1);
                exp_q.push_back(w);
            end
            src = dma_pkg::addr_t'(src + blen);
            dst = dma_pkg::addr_t'(dst + blen);
            rem = rem - blen;
            exp_bursts++;
        end
        exp_done++;
    endtask

    // Called one step after a rising edge
    task automatic send_request(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                                input int unsigned len);
        req.src_addr    = src;
        req.dst_addr    = dst;
        req.length      = dma_pkg::len_t'(len);
        req_valid       = 1'b1;
        requested_words = requested_words + len;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic set_stalls(input int unsigned rd_pct, input int unsigned wr_pct);
        rd_stall_pct = rd_pct;
        wr_stall_pct = wr_pct;
    endtask

    // Wait for all predicted words and done pulses, then a quiet window
    task automatic finish_test(input string name);
        while (done_count < exp_done || exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        compare_count(done_count, exp_done, {name, " done pulses"});
        compare_count(last_count, exp_bursts, {name, " burst ends"});
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic single_page_copy();
        set_stalls(0, 0);
        predict_transfer(16'h0010, 16'h0200, 5);
        send_request(16'h0010, 16'h0200, 5);
        finish_test("single page");
    endtask

    // Source 8 words short of its page end and destination page aligned
    task automatic source_page_cross();
        set_stalls(0, 0);
        predict_transfer(16'h0038, 16'h0400, 12);
        send_request(16'h0038, 16'h0400, 12);
        finish_test("source page cross");
    endtask

    task automatic long_split();
        set_stalls(0, 0);
        predict_transfer(16'h1013, 16'h2029, 100);
        send_request(16'h1013, 16'h2029, 100);
        finish_test("long split");
    endtask

    task automatic stalled_copy();
        set_stalls(30, 40);
        predict_transfer(16'h30f5, 16'h4007, 60);
        send_request(16'h30f5, 16'h4007, 60);
        finish_test("random stalls");
    endtask

    task automatic back_to_back();
        set_stalls(10, 20);
        predict_transfer(16'h5000, 16'h6000, 10);
        predict_transfer(16'h5100, 16'h6100, 1);
        predict_transfer(16'h513c, 16'h61f0, 7);
        send_request(16'h5000, 16'h6000, 10);
        send_request(16'h5100, 16'h6100, 1);
        send_request(16'h513c, 16'h61f0, 7);
        finish_test("back to back");
        compare_flag(req_ready, 1'b1, "req_ready after final completion");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int unsigned seed;
        seed = Seed;
        void'($urandom(seed));
        clk             = 1'b0;
        rst_n           = 1'b0;
        req             = '0;
        req_valid       = 1'b0;
        rd_stall_pct    = 0;
        wr_stall_pct    = 0;
        exp_done        = 0;
        exp_bursts      = 0;
        done_count      = 0;
        last_count      = 0;
        requested_words = 0;
        cycle_cnt       = 0;
        checks          = 0;
        errors          = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare_flag(req_ready, 1'b1, "req_ready after reset");
        compare_flag(rd_valid, 1'b0, "rd_valid after reset");
        compare_flag(wr_valid, 1'b0, "wr_valid after reset");
        compare_flag(done, 1'b0, "done after reset");
        single_page_copy();
        source_page_cross();
        long_split();
        stalled_copy();
        back_to_back();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dma_backend.f
logic/dma_pkg.sv
logic/dma_legalizer.sv
logic/dma_read_engine.sv
logic/dma_data_fifo.sv
logic/dma_write_engine.sv
logic/dma_backend.sv
testbench/tb_mem_model.sv
testbench/tb_dma_backend.sv
